// File: Makefile
# Verilator build and run of the warp control testbench

SRCS := $(shell cat sim.f)

all: run

obj_dir/Vwctl_tb: sim.f $(SRCS)
	verilator --binary -j 0 --top-module wctl_tb -f sim.f -o Vwctl_tb

run: obj_dir/Vwctl_tb
	./obj_dir/Vwctl_tb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: rtl/wctl_commit.sv
//************************************************************
// warp control commit
// two-entry elastic buffer (head plus skid), halt flag and
// warp control strobe on the last packet of a warp
//************************************************************
`timescale 1ns/1ps

module wctl_commit (
    input  logic                 clk,
    input  logic                 rst_n,
    wctl_rsp_if.sink             rsp,
    input  logic                 out_ready,
    output logic                 out_valid,
    output wctl_pkg::wctl_meta_t out_meta,
    output wctl_pkg::wctl_rec_t  out_rec,
    output logic                 out_halt,
    output logic                 out_dvg,
    output logic                 ctl_valid
);
    logic                 head_valid;
    logic                 skid_valid;
    wctl_pkg::wctl_meta_t head_meta;
    wctl_pkg::wctl_meta_t skid_meta;
    wctl_pkg::wctl_rec_t  head_rec;
    wctl_pkg::wctl_rec_t  skid_rec;
    logic                 push;
    logic                 pop;
    logic                 load_head;
    logic                 load_skid;

    // skid full means both entries are held
    assign rsp.ready = !skid_valid;

    assign push = rsp.valid && rsp.ready;
    assign pop  = head_valid && out_ready;

    // head refills from skid first to keep packets in order
    assign load_head = (pop && skid_valid) || (push && (!head_valid || pop));
    assign load_skid = push && head_valid && !pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            head_valid <= skid_valid || push || (head_valid && !pop);
            skid_valid <= (skid_valid && !pop) || load_skid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_head) begin
            head_meta <= skid_valid ? skid_meta : rsp.meta;
            head_rec  <= skid_valid ? skid_rec : rsp.rec;
        end
        if (load_skid) begin
            skid_meta <= rsp.meta;
            skid_rec  <= rsp.rec;
        end
    end

    assign out_valid = head_valid;
    assign out_meta  = head_meta;
    assign out_rec   = head_rec;

    // an empty thread mask from tmc stops the warp
    assign out_halt = head_valid && (head_rec.op == wctl_pkg::OP_TMC) &&
                      (head_rec.tmask == '0);

    assign out_dvg = head_rec.is_dvg;

    // one strobe per warp as its eop packet leaves
    assign ctl_valid = head_valid && out_ready && head_meta.eop;

endmodule

// File: rtl/wctl_decode.sv
//************************************************************
// warp control decode
// maps the opcode, selects the leader lane operands and
// extracts the per-lane taken bits
//************************************************************
`timescale 1ns/1ps

module wctl_decode #(
    parameter int NUM_LANES = 4
) (
    input  logic                                  in_valid,
    input  logic [wctl_pkg::OP_BITS-1:0]          in_op,
    input  logic [wctl_pkg::WID_BITS-1:0]         in_wid,
    input  logic [NUM_LANES-1:0]                  in_tmask,
    input  logic [wctl_pkg::XLEN-1:0]             in_pc,
    input  logic [wctl_pkg::TID_BITS-1:0]         in_tid,
    input  logic [wctl_pkg::PID_BITS-1:0]         in_pid,
    input  logic                                  in_sop,
    input  logic                                  in_eop,
    input  logic [NUM_LANES*wctl_pkg::XLEN-1:0]   in_rs1,
    input  logic [NUM_LANES*wctl_pkg::XLEN-1:0]   in_rs2,
    output logic                                  in_ready,
    wctl_dec_if.src                               dec,
    wctl_rsp_if.sink_ready                        rsp_ready
);
    localparam int XLEN     = wctl_pkg::XLEN;
    localparam int TID_BITS = wctl_pkg::TID_BITS;

    logic [TID_BITS-1:0] lead;

    // leader lane is the issuing thread's slot within the packet
    assign lead = in_tid % TID_BITS'(NUM_LANES);

    always_comb begin
        case (in_op)
            3'd1:    dec.op = wctl_pkg::OP_TMC;
            3'd2:    dec.op = wctl_pkg::OP_PRED;
            3'd3:    dec.op = wctl_pkg::OP_SPLIT;
            3'd4:    dec.op = wctl_pkg::OP_JOIN;
            3'd5:    dec.op = wctl_pkg::OP_BAR;
            3'd6:    dec.op = wctl_pkg::OP_WSPAWN;
            default: dec.op = wctl_pkg::OP_NONE;
        endcase
    end

    assign dec.rs1_lead = in_rs1[lead*XLEN +: XLEN];
    assign dec.rs2_lead = in_rs2[lead*XLEN +: XLEN];

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_taken
        assign dec.taken[i] = in_rs1[i*XLEN];
    end

    // lane mask widened to the record field
    assign dec.meta.wid   = in_wid;
    assign dec.meta.tmask = wctl_pkg::MAX_LANES'(in_tmask);
    assign dec.meta.pc    = in_pc;
    assign dec.meta.pid   = in_pid;
    assign dec.meta.sop   = in_sop;
    assign dec.meta.eop   = in_eop;

    assign dec.valid = in_valid;
    assign dec.fire  = in_valid && rsp_ready.ready;
    assign in_ready  = rsp_ready.ready;

endmodule

// File: rtl/wctl_execute.sv
//************************************************************
// warp control execute
// accumulates then/else masks over the packets of a warp and
// forms the warp control record
//************************************************************
`timescale 1ns/1ps

module wctl_execute #(
    parameter int NUM_LANES   = 4,
    parameter int NUM_THREADS = 8,
    parameter int NUM_WARPS   = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    wctl_dec_if.dst dec,
    wctl_rsp_if.src rsp
);
    localparam int XLEN        = wctl_pkg::XLEN;
    localparam int MAX_THREADS = wctl_pkg::MAX_THREADS;
    localparam int MAX_WARPS   = wctl_pkg::MAX_WARPS;
    localparam int WID_BITS    = wctl_pkg::WID_BITS;
    localparam int BAR_ID_BITS = wctl_pkg::BAR_ID_BITS;
    localparam int BAR_SZ_BITS = wctl_pkg::BAR_SZ_BITS;

    logic [NUM_THREADS-1:0] then_r;
    logic [NUM_THREADS-1:0] else_r;
    logic [NUM_THREADS-1:0] then_n;
    logic [NUM_THREADS-1:0] else_n;
    logic [NUM_LANES-1:0]   lane_mask;
    logic                   has_then;
    logic                   has_else;
    logic [NUM_WARPS-1:0]   spawn_mask;
    wctl_pkg::wctl_rec_t    rec;

    assign lane_mask = dec.meta.tmask[NUM_LANES-1:0];

    // sop starts a fresh warp and later packets add their slice
    always_comb begin
        then_n = dec.meta.sop ? '0 : then_r;
        else_n = dec.meta.sop ? '0 : else_r;
        then_n[dec.meta.pid*NUM_LANES +: NUM_LANES] = dec.taken & lane_mask;
        else_n[dec.meta.pid*NUM_LANES +: NUM_LANES] = ~dec.taken & lane_mask;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            then_r <= '0;
            else_r <= '0;
        end else if (dec.fire) begin
            then_r <= then_n;
            else_r <= else_n;
        end
    end

    assign has_then = |then_n;
    assign has_else = |else_n;

    // spawn every warp below the count, except the caller
    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_spawn
        assign spawn_mask[i] = (XLEN'(i) < dec.rs1_lead) &&
                               (WID_BITS'(i) != dec.meta.wid);
    end

    always_comb begin
        rec    = '0;
        rec.op = dec.op;
        case (dec.op)
            wctl_pkg::OP_TMC: begin
                rec.tmask = MAX_THREADS'(dec.rs1_lead[NUM_THREADS-1:0]);
            end
            wctl_pkg::OP_PRED: begin
                // nobody taken falls back to the rs2 mask
                rec.tmask = has_then ? MAX_THREADS'(then_n)
                                     : MAX_THREADS'(dec.rs2_lead[NUM_THREADS-1:0]);
            end
            wctl_pkg::OP_SPLIT: begin
                rec.tmask      = MAX_THREADS'(then_n);
                rec.else_tmask = MAX_THREADS'(else_n);
                rec.is_dvg     = has_then && has_else;
                rec.pc         = dec.meta.pc + XLEN'(4);
            end
            wctl_pkg::OP_JOIN: begin
                rec.is_dvg = dec.rs1_lead[0];
            end
            wctl_pkg::OP_BAR: begin
                rec.bar_id      = dec.rs1_lead[BAR_ID_BITS-1:0];
                rec.bar_size_m1 = dec.rs2_lead[BAR_SZ_BITS-1:0] - BAR_SZ_BITS'(1);
            end
            wctl_pkg::OP_WSPAWN: begin
                rec.wmask = MAX_WARPS'(spawn_mask);
                rec.pc    = dec.rs2_lead;
            end
            default: ;
        endcase
    end

    assign rsp.valid = dec.valid;
    assign rsp.meta  = dec.meta;
    assign rsp.rec   = rec;

endmodule

// File: rtl/wctl_ifs.sv
//************************************************************
// warp control internal buses
// decode to execute, and execute to commit with handshake
//************************************************************
`timescale 1ns/1ps

interface wctl_dec_if #(
    parameter int NUM_LANES = 4
);
    logic                          valid;
    logic                          fire;
    wctl_pkg::wctl_op_e            op;
    logic [wctl_pkg::XLEN-1:0]     rs1_lead;
    logic [wctl_pkg::XLEN-1:0]     rs2_lead;
    // bit 0 of each lane's rs1
    logic [NUM_LANES-1:0]          taken;
    wctl_pkg::wctl_meta_t          meta;

    modport src (output valid, fire, op, rs1_lead, rs2_lead, taken, meta);
    modport dst (input valid, fire, op, rs1_lead, rs2_lead, taken, meta);
endinterface

interface wctl_rsp_if;
    logic                 valid;
    logic                 ready;
    wctl_pkg::wctl_meta_t meta;
    wctl_pkg::wctl_rec_t  rec;

    modport src (output valid, meta, rec, input ready);
    modport sink (input valid, meta, rec, output ready);
    // decode only needs the ready
    modport sink_ready (input ready);
endinterface

// File: rtl/wctl_pkg.sv
//************************************************************
// warp control shared definitions
// opcodes, field widths and the records passed between the
// decode, execute and commit stages
//************************************************************
package wctl_pkg;

    localparam int XLEN = 32;

    // upper bounds that the top level parameters stay within
    localparam int MAX_THREADS = 32;
    localparam int MAX_WARPS   = 16;
    localparam int MAX_LANES   = 8;

    localparam int OP_BITS     = 3;
    localparam int WID_BITS    = 4;
    localparam int PID_BITS    = 3;
    localparam int TID_BITS    = 5;
    localparam int BAR_ID_BITS = 4;
    localparam int BAR_SZ_BITS = 8;

    // raw in_op codes use the same values
    typedef enum logic [OP_BITS-1:0] {
        OP_NONE   = 3'd0,
        OP_TMC    = 3'd1,
        OP_PRED   = 3'd2,
        OP_SPLIT  = 3'd3,
        OP_JOIN   = 3'd4,
        OP_BAR    = 3'd5,
        OP_WSPAWN = 3'd6
    } wctl_op_e;

    // one warp control record per packet
    typedef struct packed {
        wctl_op_e               op;
        logic [MAX_THREADS-1:0] tmask;
        logic [MAX_THREADS-1:0] else_tmask;
        logic                   is_dvg;
        // next pc for split, spawn pc for wspawn
        logic [XLEN-1:0]        pc;
        logic [MAX_WARPS-1:0]   wmask;
        logic [BAR_ID_BITS-1:0] bar_id;
        logic [BAR_SZ_BITS-1:0] bar_size_m1;
    } wctl_rec_t;

    // packet framing and identity
    typedef struct packed {
        logic [WID_BITS-1:0]  wid;
        logic [MAX_LANES-1:0] tmask;
        logic [XLEN-1:0]      pc;
        logic [PID_BITS-1:0]  pid;
        logic                 sop;
        logic                 eop;
    } wctl_meta_t;

endpackage

// File: rtl/wctl_top.sv
//************************************************************
// warp control unit top level
// decode, mask accumulation and commit buffering behind
// plain ports
//************************************************************
`timescale 1ns/1ps

module wctl_top #(
    parameter int NUM_LANES   = 4,
    parameter int NUM_THREADS = 8,
    parameter int NUM_WARPS   = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   in_valid,
    input  logic [wctl_pkg::OP_BITS-1:0]           in_op,
    input  logic [wctl_pkg::WID_BITS-1:0]          in_wid,
    input  logic [NUM_LANES-1:0]                   in_tmask,
    input  logic [wctl_pkg::XLEN-1:0]              in_pc,
    input  logic [wctl_pkg::TID_BITS-1:0]          in_tid,
    input  logic [wctl_pkg::PID_BITS-1:0]          in_pid,
    input  logic                                   in_sop,
    input  logic                                   in_eop,
    input  logic [NUM_LANES*wctl_pkg::XLEN-1:0]    in_rs1,
    input  logic [NUM_LANES*wctl_pkg::XLEN-1:0]    in_rs2,
    output logic                                   in_ready,
    input  logic                                   out_ready,
    output logic                                   out_valid,
    output logic [wctl_pkg::WID_BITS-1:0]          out_wid,
    output logic [NUM_LANES-1:0]                   out_tmask,
    output logic [wctl_pkg::XLEN-1:0]              out_pc,
    output logic [wctl_pkg::PID_BITS-1:0]          out_pid,
    output logic                                   out_sop,
    output logic                                   out_eop,
    output logic                                   out_halt,
    output logic                                   out_dvg,
    output logic                                   ctl_valid,
    output logic [wctl_pkg::WID_BITS-1:0]          ctl_wid,
    output logic [wctl_pkg::OP_BITS-1:0]           ctl_op,
    output logic [NUM_THREADS-1:0]                 ctl_tmask,
    output logic [NUM_THREADS-1:0]                 ctl_else_tmask,
    output logic                                   ctl_is_dvg,
    output logic [wctl_pkg::XLEN-1:0]              ctl_pc,
    output logic [NUM_WARPS-1:0]                   ctl_wmask,
    output logic [wctl_pkg::BAR_ID_BITS-1:0]       ctl_bar_id,
    output logic [wctl_pkg::BAR_SZ_BITS-1:0]       ctl_bar_size_m1
);
    wctl_pkg::wctl_meta_t head_meta;
    wctl_pkg::wctl_rec_t  head_rec;

    wctl_dec_if #(.NUM_LANES(NUM_LANES)) dec_bus ();
    wctl_rsp_if rsp_bus ();

    wctl_decode #(.NUM_LANES(NUM_LANES)) u_decode (
        .in_valid (in_valid), .in_op (in_op), .in_wid (in_wid),
        .in_tmask (in_tmask), .in_pc (in_pc), .in_tid (in_tid),
        .in_pid   (in_pid), .in_sop (in_sop), .in_eop (in_eop),
        .in_rs1   (in_rs1), .in_rs2 (in_rs2), .in_ready (in_ready),
        .dec      (dec_bus.src), .rsp_ready (rsp_bus.sink_ready)
    );

    wctl_execute #(
        .NUM_LANES   (NUM_LANES),
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) u_execute (
        .clk (clk), .rst_n (rst_n), .dec (dec_bus.dst), .rsp (rsp_bus.src)
    );

    wctl_commit u_commit (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp       (rsp_bus.sink),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_meta  (head_meta),
        .out_rec   (head_rec),
        .out_halt  (out_halt),
        .out_dvg   (out_dvg),
        .ctl_valid (ctl_valid)
    );

    // commit side view of the head entry
    assign out_wid   = head_meta.wid;
    assign out_tmask = head_meta.tmask[NUM_LANES-1:0];
    assign out_pc    = head_meta.pc;
    assign out_pid   = head_meta.pid;
    assign out_sop   = head_meta.sop;
    assign out_eop   = head_meta.eop;

    // warp control fields trimmed to the configured sizes
    assign ctl_wid         = head_meta.wid;
    assign ctl_op          = head_rec.op;
    assign ctl_tmask       = head_rec.tmask[NUM_THREADS-1:0];
    assign ctl_else_tmask  = head_rec.else_tmask[NUM_THREADS-1:0];
    assign ctl_is_dvg      = head_rec.is_dvg;
    assign ctl_pc          = head_rec.pc;
    assign ctl_wmask       = head_rec.wmask[NUM_WARPS-1:0];
    assign ctl_bar_id      = head_rec.bar_id;
    assign ctl_bar_size_m1 = head_rec.bar_size_m1;

endmodule

// File: sim.f
rtl/wctl_pkg.sv
rtl/wctl_ifs.sv
rtl/wctl_decode.sv
rtl/wctl_execute.sv
rtl/wctl_commit.sv
rtl/wctl_top.sv
verification/wctl_tb.sv

// File: verification/wctl_tb.sv
//************************************************************
// warp control unit testbench
// plays the packet trace, applies back-pressure on the commit
// side and checks every committed packet
//************************************************************
`timescale 1ns/1ps

module wctl_tb;
    localparam int NUM_LANES   = 4;
    localparam int NUM_THREADS = 8;
    localparam int NUM_WARPS   = 4;
    localparam int XLEN        = wctl_pkg::XLEN;
    localparam int NUM_FIELDS  = 12;

    typedef struct packed {
        logic                      bp;
        logic [2:0]                op;
        logic [3:0]                wid;
        logic [NUM_LANES-1:0]      tmask;
        logic [XLEN-1:0]           pc;
        logic [4:0]                tid;
        logic [2:0]                pid;
        logic                      sop;
        logic                      eop;
        logic [NUM_LANES*XLEN-1:0] rs1;
        logic [NUM_LANES*XLEN-1:0] rs2;
    } stim_t;

    // framing of a packet the buffer has taken
    typedef struct packed {
        logic                 sop;
        logic [2:0]           pid;
        logic [NUM_LANES-1:0] tmask;
    } sent_t;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      in_valid, in_sop, in_eop, in_ready;
    logic [2:0]                in_op, in_pid;
    logic [3:0]                in_wid;
    logic [NUM_LANES-1:0]      in_tmask;
    logic [XLEN-1:0]           in_pc;
    logic [4:0]                in_tid;
    logic [NUM_LANES*XLEN-1:0] in_rs1, in_rs2;
    logic                      out_ready = 1'b1;
    logic                      out_valid, out_sop, out_eop, out_halt, out_dvg;
    logic [3:0]                out_wid, ctl_wid, ctl_bar_id;
    logic [NUM_LANES-1:0]      out_tmask;
    logic [XLEN-1:0]           out_pc, ctl_pc;
    logic [2:0]                out_pid, ctl_op;
    logic                      ctl_valid, ctl_is_dvg;
    logic [NUM_THREADS-1:0]    ctl_tmask, ctl_else_tmask;
    logic [NUM_WARPS-1:0]      ctl_wmask;
    logic [7:0]                ctl_bar_size_m1;

    stim_t       stim_q[$];
    sent_t       sent_q[$];
    logic [31:0] exp_q[$];
    string       field_name [NUM_FIELDS] = '{"out_wid", "out_pc", "out_eop", "out_halt",
        "out_dvg", "ctl_op", "ctl_tmask", "ctl_else_tmask", "ctl_pc", "ctl_wmask",
        "ctl_bar_id", "ctl_bar_size_m1"};
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          records = 0;
    int          limit;
    logic [31:0] lfsr = 32'h7aab_bf70;
    logic        bp_mode = 1'b0;

    wctl_top #(
        .NUM_LANES   (NUM_LANES),
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) uut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32 22 2 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_rand_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("FAIL %s at %0t: got %h, expected %h", name, $time, got, want);
            errors++;
        end
    endtask

    task automatic read_trace(output bit ok);
        int               fd;
        int               code;
        int               l;
        logic [7:0]       tag;
        logic [31:0]      f [16];
        logic [8*256-1:0] rest;
        stim_t            s;
        logic             bp;
        bp = 1'b0;
        ok = 1'b0;
        fd = $fopen("verification/wctl_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    continue;
                end
                if (tag == "B") begin
                    bp = 1'b1;
                end else if (tag == "I") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    s.bp    = bp;
                    s.op    = f[0][2:0];
                    s.wid   = f[1][3:0];
                    s.tmask = f[2][NUM_LANES-1:0];
                    s.pc    = f[3];
                    s.tid   = f[4][4:0];
                    s.pid   = f[5][2:0];
                    s.sop   = f[6][0];
                    s.eop   = f[7][0];
                    // operands come in rs1 rs2 pairs starting at lane 0
                    for (l = 0; l < NUM_LANES; l++) begin
                        s.rs1[l*XLEN +: XLEN] = f[8+2*l];
                        s.rs2[l*XLEN +: XLEN] = f[9+2*l];
                    end
                    stim_q.push_back(s);
                    records++;
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    code = $fscanf(fd, "%h %h %h %h %h %h", f[6], f[7], f[8], f[9], f[10], f[11]);
                    for (l = 0; l < NUM_FIELDS; l++) begin
                        exp_q.push_back(f[l]);
                    end
                    records++;
                end else begin
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // about 3 in 4 cycles ready during the back-pressure phase
    always @(negedge clk) begin : ready_drive
        logic b0;
        logic b1;
        if (bp_mode) begin
            next_rand_bit(b0);
            next_rand_bit(b1);
            out_ready = b0 | b1;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin : monitor
        logic [31:0] got [NUM_FIELDS];
        logic [31:0] want [NUM_FIELDS];
        sent_t       sent;
        int          k;
        if (rst_n) begin
            // buffer model holds every accepted and not yet committed packet
            check_value("out_valid", 32'(out_valid), 32'(sent_q.size() != 0));
            check_value("in_ready", 32'(in_ready), 32'(sent_q.size() < 2));
            if (out_valid && out_ready) begin
                // framing comes back as it was sent
                if (sent_q.size() != 0) begin
                    sent = sent_q.pop_front();
                    check_value("out_tmask", 32'(out_tmask), 32'(sent.tmask));
                    check_value("out_pid", 32'(out_pid), 32'(sent.pid));
                    check_value("out_sop", 32'(out_sop), 32'(sent.sop));
                end
                if (exp_q.size() < NUM_FIELDS) begin
                    $display("a packet committed with no expected entry left");
                    errors++;
                end else begin
                    got = '{32'(out_wid), out_pc, 32'(out_eop), 32'(out_halt), 32'(out_dvg),
                            32'(ctl_op), 32'(ctl_tmask), 32'(ctl_else_tmask), ctl_pc,
                            32'(ctl_wmask), 32'(ctl_bar_id), 32'(ctl_bar_size_m1)};
                    for (k = 0; k < NUM_FIELDS; k++) begin
                        want[k] = exp_q.pop_front();
                        check_value(field_name[k], got[k], want[k]);
                    end
                    check_value("ctl_wid", 32'(ctl_wid), want[0]);
                    check_value("ctl_is_dvg", 32'(ctl_is_dvg), want[4]);
                    // strobe only on the last packet of a warp
                    check_value("ctl_valid", 32'(ctl_valid), want[2]);
                end
            end else begin
                check_value("ctl_valid", 32'(ctl_valid), 32'd0);
            end
            if (in_valid && in_ready) begin
                sent.sop   = in_sop;
                sent.pid   = in_pid;
                sent.tmask = in_tmask;
                sent_q.push_back(sent);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles with %0d commits still missing",
                     cycles, exp_q.size() / NUM_FIELDS);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin : main
        bit    ok;
        stim_t s;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_op    = '0;
        in_wid   = '0;
        in_tmask = '0;
        in_pc    = '0;
        in_tid   = '0;
        in_pid   = '0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        in_rs1   = '0;
        in_rs2   = '0;
        read_trace(ok);
        limit = 20 * records + 100;
        if (!ok) begin
            $display("cannot open the trace file");
            $display("Done: errors found");
            $finish;
        end else begin
            repeat (10) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("ctl_valid", 32'(ctl_valid), 32'd0);
            check_value("out_halt", 32'(out_halt), 32'd0);
            check_value("in_ready", 32'(in_ready), 32'd1);
            foreach (stim_q[i]) begin
                bp_mode = stim_q[i].bp;
                s = stim_q[i];
                @(negedge clk);
                in_valid = 1'b1;
                in_op    = s.op;
                in_wid   = s.wid;
                in_tmask = s.tmask;
                in_pc    = s.pc;
                in_tid   = s.tid;
                in_pid   = s.pid;
                in_sop   = s.sop;
                in_eop   = s.eop;
                in_rs1   = s.rs1;
                in_rs2   = s.rs2;
                // hold until the buffer takes it
                @(posedge clk);
                while (!in_ready) @(posedge clk);
            end
            @(negedge clk);
            in_valid = 1'b0;
            while (exp_q.size() != 0) @(posedge clk);
            repeat (3) @(posedge clk);
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// File: verification/wctl_trace.txt
# I op wid tmask pc tid pid sop eop, then rs1 rs2 per lane from lane 0, all hex
# E wid pc eop halt dvg op tmask else_tmask ctl_pc wmask bar_id bar_size_m1; B starts back-pressure
I 1 0 f 100 0 0 1 1 ff 0 0 0 0 0 0 0
E 0 100 1 0 0 1 ff 0 0 0 0 0
I 1 1 f 104 6 0 1 1 3f 0 7 0 0 0 1 0
E 1 104 1 1 0 1 0 0 0 0 0 0
I 3 2 f 200 0 0 1 0 1 0 0 0 1 0 1 0
E 2 200 0 0 1 3 d 2 204 0 0 0
I 3 2 f 200 4 1 0 1 0 0 1 0 1 0 0 0
E 2 200 1 0 1 3 6d 92 204 0 0 0
I 3 3 f 300 0 0 1 1 1 0 1 0 1 0 1 0
E 3 300 1 0 0 3 f 0 304 0 0 0
I 2 0 3 400 0 0 1 1 1 0 0 0 1 0 1 0
E 0 400 1 0 0 2 1 0 0 0 0 0
I 2 1 f 404 0 0 1 1 0 a5 0 0 0 0 0 0
E 1 404 1 0 0 2 a5 0 0 0 0 0
I 4 2 f 500 1 0 1 1 0 0 1 0 0 0 0 0
E 2 500 1 0 1 4 0 0 0 0 0 0
I 4 2 f 504 0 0 1 1 2 0 0 0 0 0 0 0
E 2 504 1 0 0 4 0 0 0 0 0 0
I 5 3 f 600 0 0 1 1 5 4 0 0 0 0 0 0
E 3 600 1 0 0 5 0 0 0 0 5 3
I 6 1 f 700 0 0 1 1 3 1000 0 0 0 0 0 0
E 1 700 1 0 0 6 0 0 1000 5 0 0
B
I 1 2 f 800 3 0 1 1 0 0 0 0 0 0 3c 0
E 2 800 1 0 0 1 3c 0 0 0 0 0
I 3 0 7 900 0 0 1 0 0 0 0 0 0 0 1 0
E 0 900 0 0 0 3 0 7 904 0 0 0
I 3 0 f 900 4 1 0 1 1 0 1 0 0 0 0 0
E 0 900 1 0 1 3 30 c7 904 0 0 0
I 5 1 f a00 0 0 1 1 f 20 0 0 0 0 0 0
E 1 a00 1 0 0 5 0 0 0 0 f 1f
I 6 0 f b00 0 0 1 1 4 2000 0 0 0 0 0 0
E 0 b00 1 0 0 6 0 0 2000 e 0 0
I 2 2 f d00 0 0 1 1 0 0 1 0 0 0 1 0
E 2 d00 1 0 0 2 a 0 0 0 0 0
I 7 1 f f00 0 0 1 1 ff ff 0 0 0 0 0 0
E 1 f00 1 0 0 0 0 0 0 0 0 0
